// ==== design/window_pkg.sv ====
package window_pkg;

    // frame geometry
    localparam int unsigned FRAME_LEN = 64;
    localparam int unsigned LANES     = 4;
    localparam int unsigned GROUPS    = FRAME_LEN / LANES;
    localparam int unsigned GROUP_W   = $clog2(GROUPS);
    localparam int unsigned IDX_W     = $clog2(FRAME_LEN);

    // data widths
    localparam int unsigned SAMPLE_W  = 12;
    localparam int unsigned COEF_W    = 12;
    localparam int unsigned PROD_W    = SAMPLE_W + COEF_W;

    // coefficients are Q1.11, result is product[22:11]
    localparam int unsigned FRAC_BITS = 11;

    // hamming table, 64 hex entries, symmetric
    localparam string COEF_FILE = "design/hamming_coeff.mem";

endpackage

// ==== design/apb_map_pkg.sv ====
package apb_map_pkg;

    localparam int unsigned APB_AW = 12;
    localparam int unsigned APB_DW = 32;

    // register map
    localparam logic [APB_AW-1:0] ADDR_CTRL   = 12'h000;
    localparam logic [APB_AW-1:0] ADDR_STATUS = 12'h004;
    localparam logic [APB_AW-1:0] SAMPLE_BASE = 12'h100;
    localparam logic [APB_AW-1:0] RESULT_BASE = 12'h200;

    // STATUS fields
    localparam int unsigned BUSY_BIT = 0;
    localparam int unsigned DONE_BIT = 1;

endpackage

// ==== design/apb_window_regs.sv ====
`timescale 1ns/1ps

module apb_window_regs import window_pkg::*, apb_map_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic [APB_AW-1:0]   paddr,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [APB_DW-1:0]   pwdata,
    output logic [APB_DW-1:0]   prdata,
    output logic                pready,
    output logic                pslverr,
    output logic                smp_wr_en,
    output logic [IDX_W-1:0]    smp_wr_idx,
    output logic [SAMPLE_W-1:0] smp_wr_data,
    output logic                start,
    input  logic                frame_done,
    output logic [IDX_W-1:0]    rd_idx,
    input  logic [SAMPLE_W-1:0] rd_data
);

    logic busy;
    logic done;
    logic access;
    logic is_ctrl, is_status, is_sample, is_result;
    logic err;
    logic wr_ok, rd_ok;

    assign access = psel & penable;

    // 64 word-spaced entries per buffer window, unaligned addresses are unmapped
    assign is_ctrl   = (paddr == ADDR_CTRL);
    assign is_status = (paddr == ADDR_STATUS);
    assign is_sample = (paddr[APB_AW-1:IDX_W+2] == SAMPLE_BASE[APB_AW-1:IDX_W+2])
                       && (paddr[1:0] == 2'b00);
    assign is_result = (paddr[APB_AW-1:IDX_W+2] == RESULT_BASE[APB_AW-1:IDX_W+2])
                       && (paddr[1:0] == 2'b00);

    always_comb begin
        err = !(is_ctrl | is_status | is_sample | is_result);
        if (pwrite && (is_status || is_result))
            err = 1'b1;
        if (!pwrite && (is_ctrl || is_sample))
            err = 1'b1;
        // buffer and control are locked while a frame runs
        if (pwrite && busy && (is_ctrl || is_sample))
            err = 1'b1;
    end

    assign wr_ok   = access & pwrite & ~err;
    assign rd_ok   = access & ~pwrite & ~err;
    assign pready  = 1'b1;
    assign pslverr = access & err;

    assign smp_wr_en   = wr_ok & is_sample;
    assign smp_wr_idx  = paddr[IDX_W+1:2];
    assign smp_wr_data = pwdata[SAMPLE_W-1:0];
    assign rd_idx      = paddr[IDX_W+1:2];

    always_comb begin
        prdata = '0;
        if (rd_ok && is_status) begin
            prdata[BUSY_BIT] = busy;
            prdata[DONE_BIT] = done;
        end else if (rd_ok && is_result) begin
            prdata[SAMPLE_W-1:0] = rd_data;
        end
    end

    // start is bit 0 of CTRL
    always_ff @(posedge clk) begin
        if (rst) begin
            start <= 1'b0;
            busy  <= 1'b0;
            done  <= 1'b0;
        end else begin
            start <= wr_ok & is_ctrl & pwdata[0];
            if (wr_ok && is_ctrl && pwdata[0]) begin
                busy <= 1'b1;
                done <= 1'b0;
            end else if (frame_done) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

endmodule

// ==== design/frame_loader.sv ====
`timescale 1ns/1ps

module frame_loader import window_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                smp_wr_en,
    input  logic [IDX_W-1:0]    smp_wr_idx,
    input  logic [SAMPLE_W-1:0] smp_wr_data,
    input  logic                start,
    output logic                grp_valid,
    output logic [GROUP_W-1:0]  grp_idx,
    output logic [SAMPLE_W-1:0] grp_sample [LANES]
);

    localparam int unsigned LANE_W = IDX_W - GROUP_W;

    logic [SAMPLE_W-1:0] smp_buf [FRAME_LEN];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < FRAME_LEN; i++)
                smp_buf[i] <= '0;
        end else if (smp_wr_en) begin
            smp_buf[smp_wr_idx] <= smp_wr_data;
        end
    end

    // group counter, one group per cycle for GROUPS cycles
    always_ff @(posedge clk) begin
        if (rst) begin
            grp_valid <= 1'b0;
            grp_idx   <= '0;
        end else if (start) begin
            grp_valid <= 1'b1;
            grp_idx   <= '0;
        end else if (grp_valid) begin
            grp_idx <= grp_idx + 1'b1;
            if (grp_idx == GROUP_W'(GROUPS - 1))
                grp_valid <= 1'b0;
        end
    end

    // lane n gets sample grp_idx*LANES + n
    for (genvar n = 0; n < LANES; n++) begin : taps
        assign grp_sample[n] = smp_buf[{grp_idx, LANE_W'(n)}];
    end

endmodule

// ==== design/window_lane.sv ====
`timescale 1ns/1ps

module window_lane import window_pkg::*; #(
    parameter int unsigned LANE_ID = 0
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                grp_valid,
    input  logic [GROUP_W-1:0]  grp_idx,
    input  logic [SAMPLE_W-1:0] sample,
    output logic                res_valid,
    output logic [GROUP_W-1:0]  res_grp,
    output logic [SAMPLE_W-1:0] res_value
);

    localparam int unsigned LANE_W = IDX_W - GROUP_W;

    logic [COEF_W-1:0]  coef_rom [FRAME_LEN];
    logic [PROD_W-1:0]  prod_s1;
    logic               valid_s1;
    logic [GROUP_W-1:0] grp_s1;

    initial $readmemh(COEF_FILE, coef_rom);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_s1  <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            valid_s1  <= grp_valid;
            res_valid <= valid_s1;
        end
    end

    // stage 1 multiply, stage 2 drops the Q1.11 fraction
    always_ff @(posedge clk) begin
        prod_s1   <= PROD_W'(sample) * PROD_W'(coef_rom[{grp_idx, LANE_W'(LANE_ID)}]);
        grp_s1    <= grp_idx;
        res_value <= prod_s1[FRAC_BITS+SAMPLE_W-1:FRAC_BITS];
        res_grp   <= grp_s1;
    end

endmodule

// ==== design/frame_collector.sv ====
`timescale 1ns/1ps

module frame_collector import window_pkg::*; (
    input  logic                clk,
    input  logic                rst,
    input  logic                res_valid [LANES],
    input  logic [GROUP_W-1:0]  res_grp   [LANES],
    input  logic [SAMPLE_W-1:0] res_value [LANES],
    output logic                frame_done,
    input  logic [IDX_W-1:0]    rd_idx,
    output logic [SAMPLE_W-1:0] rd_data
);

    localparam int unsigned LANE_W = IDX_W - GROUP_W;

    logic [SAMPLE_W-1:0] res_buf [FRAME_LEN];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < FRAME_LEN; i++)
                res_buf[i] <= '0;
        end else begin
            for (int n = 0; n < LANES; n++) begin
                if (res_valid[n])
                    res_buf[{res_grp[n], LANE_W'(n)}] <= res_value[n];
            end
        end
    end

    // lanes run in lockstep, the last lane holds sample 63
    always_ff @(posedge clk) begin
        if (rst)
            frame_done <= 1'b0;
        else
            frame_done <= res_valid[LANES-1] && (res_grp[LANES-1] == GROUP_W'(GROUPS - 1));
    end

    assign rd_data = res_buf[rd_idx];

endmodule

// ==== design/window_top.sv ====
`timescale 1ns/1ps

module window_top import window_pkg::*, apb_map_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [APB_AW-1:0] paddr,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [APB_DW-1:0] pwdata,
    output logic [APB_DW-1:0] prdata,
    output logic              pready,
    output logic              pslverr
);

    logic                smp_wr_en;
    logic [IDX_W-1:0]    smp_wr_idx;
    logic [SAMPLE_W-1:0] smp_wr_data;
    logic                start;
    logic                frame_done;
    logic [IDX_W-1:0]    rd_idx;
    logic [SAMPLE_W-1:0] rd_data;

    logic                grp_valid;
    logic [GROUP_W-1:0]  grp_idx;
    logic [SAMPLE_W-1:0] grp_sample [LANES];

    logic                res_valid [LANES];
    logic [GROUP_W-1:0]  res_grp   [LANES];
    logic [SAMPLE_W-1:0] res_value [LANES];

    apb_window_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .smp_wr_en   (smp_wr_en),
        .smp_wr_idx  (smp_wr_idx),
        .smp_wr_data (smp_wr_data),
        .start       (start),
        .frame_done  (frame_done),
        .rd_idx      (rd_idx),
        .rd_data     (rd_data)
    );

    frame_loader u_loader (
        .clk         (clk),
        .rst         (rst),
        .smp_wr_en   (smp_wr_en),
        .smp_wr_idx  (smp_wr_idx),
        .smp_wr_data (smp_wr_data),
        .start       (start),
        .grp_valid   (grp_valid),
        .grp_idx     (grp_idx),
        .grp_sample  (grp_sample)
    );

    for (genvar n = 0; n < LANES; n++) begin : lanes
        window_lane #(.LANE_ID(n)) u_lane (
            .clk       (clk),
            .rst       (rst),
            .grp_valid (grp_valid),
            .grp_idx   (grp_idx),
            .sample    (grp_sample[n]),
            .res_valid (res_valid[n]),
            .res_grp   (res_grp[n]),
            .res_value (res_value[n])
        );
    end

    frame_collector u_collector (
        .clk        (clk),
        .rst        (rst),
        .res_valid  (res_valid),
        .res_grp    (res_grp),
        .res_value  (res_value),
        .frame_done (frame_done),
        .rd_idx     (rd_idx),
        .rd_data    (rd_data)
    );

endmodule

// ==== test/tb_window_top.sv ====
`timescale 1ns/1ps

module tb_window_top import window_pkg::*, apb_map_pkg::*; ();

    // about 1000 transfers of 2 cycles over all tests, plus margin
    localparam int TIMEOUT_CYCLES = 3000;
    localparam int DONE_LIMIT     = 20;

    logic              clk;
    logic              rst;
    logic [APB_AW-1:0] paddr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [APB_DW-1:0] pwdata;
    logic [APB_DW-1:0] prdata;
    logic              pready;
    logic              pslverr;

    logic [COEF_W-1:0]   coef      [FRAME_LEN];
    logic [SAMPLE_W-1:0] model_smp [FRAME_LEN];
    logic [APB_DW-1:0]   res_rd    [FRAME_LEN];
    logic [31:0]         lfsr;
    int                  cycles;
    int                  errors;
    int                  test_base;
    int                  access_cycle;
    logic [APB_DW-1:0]   exp_q [$];
    logic [APB_DW-1:0]   got_q [$];
    string               name_q [$];

    window_top UUT (
        .clk     (clk),
        .rst     (rst),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    always @(negedge clk) begin : compare
        logic [APB_DW-1:0] e;
        logic [APB_DW-1:0] g;
        string             n;
        while (got_q.size() > 0) begin
            e = exp_q.pop_front();
            g = got_q.pop_front();
            n = name_q.pop_front();
            if (g !== e) begin
                $display("[FAIL] %s expected %h got %h", n, e, g);
                errors++;
            end
        end
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [SAMPLE_W-1:0] rand_sample();
        logic [SAMPLE_W-1:0] v;
        v = '0;
        for (int b = 0; b < SAMPLE_W; b++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[SAMPLE_W-2:0], lfsr[0]};
        end
        return v;
    endfunction

    // sample times Q1.11 coefficient, keep bits 22..11
    function automatic logic [SAMPLE_W-1:0] ref_window(input logic [SAMPLE_W-1:0] s,
                                                        input logic [COEF_W-1:0] c);
        logic [23:0] p;
        p = 24'(s) * 24'(c);
        return p[22:11];
    endfunction

    // called 2 ns after a rising edge, returns at the same point
    task automatic apb_xfer(input logic wr, input logic [APB_AW-1:0] addr,
                            input logic [APB_DW-1:0] wdata,
                            output logic [APB_DW-1:0] rdata, output logic err);
        paddr   = addr;
        pwrite  = wr;
        pwdata  = wdata;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #2 penable = 1'b1;
        @(negedge clk);
        rdata = prdata;
        err = pslverr;
        access_cycle = cycles;
        if (pready !== 1'b1) begin
            $display("[FAIL] pready expected 1 got %h", pready);
            errors++;
        end
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data,
                             output logic err);
        logic [APB_DW-1:0] unused;
        apb_xfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data,
                            output logic err);
        apb_xfer(1'b0, addr, '0, data, err);
    endtask

    task automatic check_value(input string name, input logic [APB_DW-1:0] got,
                               input logic [APB_DW-1:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic expect_err(input string what, input logic err, input logic want);
        if (err !== want) begin
            $display("[FAIL] pslverr on %s expected %h got %h", what, want, err);
            errors++;
        end
    endtask

    // mode 0 random, 1 full scale, 2 zero
    task automatic write_frame(input int mode);
        logic [SAMPLE_W-1:0] s;
        logic                err;
        for (int i = 0; i < FRAME_LEN; i++) begin
            s = (mode == 0) ? rand_sample() : ((mode == 1) ? 12'hfff : 12'h000);
            apb_write(SAMPLE_BASE + APB_AW'(4 * i), APB_DW'(s), err);
            expect_err("sample write", err, 1'b0);
            model_smp[i] = s;
        end
    endtask

    task automatic start_frame();
        logic err;
        apb_write(ADDR_CTRL, 32'h1, err);
        expect_err("CTRL write", err, 1'b0);
    endtask

    task automatic wait_done();
        logic [APB_DW-1:0] d;
        logic              err;
        do begin
            apb_read(ADDR_STATUS, d, err);
        end while (!d[DONE_BIT]);
    endtask

    task automatic check_results();
        logic [APB_DW-1:0] d;
        logic              err;
        for (int i = 0; i < FRAME_LEN; i++) begin
            apb_read(RESULT_BASE + APB_AW'(4 * i), d, err);
            expect_err("result read", err, 1'b0);
            res_rd[i] = d;
            exp_q.push_back(APB_DW'(ref_window(model_smp[i], coef[i])));
            got_q.push_back(d);
            name_q.push_back($sformatf("RESULT[%0d]", i));
        end
    endtask

    task automatic finish_test(input string name);
        @(posedge clk);
        @(posedge clk);
        #2;
        $display("test %s: %0d errors", name, errors - test_base);
        test_base = errors;
    endtask

    initial begin : main
        logic [APB_DW-1:0] d;
        logic              err;
        int                ctrl_cycle;
        clk = 1'b0;
        rst = 1'b1;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        cycles = 0;
        errors = 0;
        test_base = 0;
        lfsr = 32'h3e3c6d84;
        for (int i = 0; i < FRAME_LEN; i++)
            model_smp[i] = '0;
        $readmemh(COEF_FILE, coef);
        repeat (3) @(posedge clk);
        #2 rst = 1'b0;

        apb_read(ADDR_STATUS, d, err);
        check_value("STATUS", d, 32'h0);
        expect_err("STATUS read", err, 1'b0);
        apb_write(ADDR_CTRL, 32'h0, err);
        expect_err("CTRL write of 0", err, 1'b0);
        apb_write(SAMPLE_BASE, 32'h0, err);
        expect_err("sample write", err, 1'b0);
        check_results();
        finish_test("reset");

        write_frame(0);
        start_frame();
        wait_done();
        check_results();
        finish_test("random_frame");

        start_frame();
        ctrl_cycle = access_cycle;
        @(posedge clk);
        #2;
        apb_read(ADDR_STATUS, d, err);
        check_value("STATUS", d, 32'h1);
        wait_done();
        if (access_cycle - ctrl_cycle - 1 > DONE_LIMIT) begin
            $display("done was seen %0d cycles after the start access, limit is %0d",
                     access_cycle - ctrl_cycle - 1, DONE_LIMIT);
            errors++;
        end
        start_frame();
        apb_read(ADDR_STATUS, d, err);
        check_value("STATUS", d, 32'h1);
        wait_done();
        finish_test("status_timing");

        write_frame(1);
        start_frame();
        wait_done();
        check_results();
        for (int i = 0; i < FRAME_LEN / 2; i++)
            check_value($sformatf("RESULT[%0d] mirror", i), res_rd[i], res_rd[FRAME_LEN - 1 - i]);
        write_frame(2);
        start_frame();
        wait_done();
        check_results();
        finish_test("edge_frames");

        apb_write(12'h008, 32'h1, err);
        expect_err("unmapped write", err, 1'b1);
        apb_write(RESULT_BASE, 32'h5, err);
        expect_err("result write", err, 1'b1);
        apb_read(SAMPLE_BASE, d, err);
        expect_err("sample read", err, 1'b1);
        write_frame(0);
        start_frame();
        apb_write(SAMPLE_BASE + APB_AW'(4 * 5), APB_DW'(~model_smp[5]), err);
        expect_err("sample write while busy", err, 1'b1);
        wait_done();
        check_results();
        start_frame();
        wait_done();
        check_results();
        finish_test("errors");

        for (int f = 0; f < 2; f++) begin
            write_frame(0);
            start_frame();
            wait_done();
            check_results();
        end
        finish_test("back_to_back");

        $display("summary: %0d errors", errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== test/window_top_sva.sv ====
`timescale 1ns/1ps

module window_top_sva (
    input logic clk,
    input logic rst,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic pslverr,
    input logic start,
    input logic grp_valid,
    input logic busy,
    input logic done
);

    logic       pending;
    logic [5:0] wait_cnt;

    // cycles from the start pulse until done is seen
    always_ff @(posedge clk) begin
        if (rst) begin
            pending  <= 1'b0;
            wait_cnt <= '0;
        end else if (start) begin
            pending  <= 1'b1;
            wait_cnt <= '0;
        end else if (pending && done) begin
            pending <= 1'b0;
        end else if (pending) begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    a_pready_high: assert property (@(posedge clk) disable iff (rst) pready)
        else $error("pready dropped low");

    a_slverr_access: assert property (@(posedge clk) disable iff (rst)
        pslverr |-> (psel && penable))
        else $error("pslverr outside an access phase");

    a_grp_in_busy: assert property (@(posedge clk) disable iff (rst) grp_valid |-> busy)
        else $error("group issued while not busy");

    a_done_latency: assert property (@(posedge clk) disable iff (rst)
        pending |-> (wait_cnt < 6'd20))
        else $error("done late after start pulse");

endmodule

bind window_top window_top_sva u_sva (
    .clk       (clk),
    .rst       (rst),
    .psel      (psel),
    .penable   (penable),
    .pready    (pready),
    .pslverr   (pslverr),
    .start     (start),
    .grp_valid (grp_valid),
    .busy      (u_regs.busy),
    .done      (u_regs.done)
);

// ==== design/hamming_coeff.mem ====
// hamming window, 0.54 - 0.46*cos(2*pi*n/63) in Q1.11, one 12-bit hex coefficient per line, n = 0..63
0a3
0a8
0b6
0cd
0ed
116
147
180
1c0
206
252
2a4
2f9
352
3ae
40b
469
4c7
523
57d
5d5
628
677
6c1
704
740
775
7a2
7c7
7e2
7f5
7fe
7fe
7f5
7e2
7c7
7a2
775
740
704
6c1
677
628
5d5
57d
523
4c7
469
40b
3ae
352
2f9
2a4
252
206
1c0
180
147
116
0ed
0cd
0b6
0a8
0a3

// ==== all.f ====
design/window_pkg.sv
design/apb_map_pkg.sv
design/apb_window_regs.sv
design/frame_loader.sv
design/window_lane.sv
design/frame_collector.sv
design/window_top.sv
test/tb_window_top.sv
test/window_top_sva.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module tb_window_top \
    -f all.f -Mdir obj_dir -o sim > build.log 2>&1 &&
./obj_dir/sim > sim.log 2>&1
grep -q "TESTS PASSED" sim.log && echo "simulation passed" || { echo "simulation failed, see sim.log"; exit 1; }
